/* include/gem_rx_settings.svh */
`ifndef GEM_RX_SETTINGS_SVH
`define GEM_RX_SETTINGS_SVH

// --------------------
// Frame geometry
// --------------------
`define GEM_DATA_WIDTH 56  // Comparator bits per frame
`define K_CHAR_WIDTH   8   // K character per frame

// --------------------
// Counters and delay
// --------------------
`define COUNT_WIDTH    16  // Status counters
`define LINK_ERR_WIDTH 8   // Transceiver error counter
`define DELAY_DEPTH    16  // Taps in the bunch-crossing delay

// --------------------
// K character codes
// --------------------
`define K_OVERFLOW     8'hFC  // Overflow marker
`define K_BC0          8'h1C  // Bunch-crossing zero marker
`define K_RESYNC       8'h3C  // Resync marker

`endif

/* verilog/gem_frame_pkg.sv */
`include "gem_rx_settings.svh"

package gem_frame_pkg;

  // --------------------
  // Basic fields
  // --------------------
  typedef logic [`GEM_DATA_WIDTH-1:0] gem_data_t;  // One frame of comparator data
  typedef logic [`K_CHAR_WIDTH-1:0]   k_char_t;    // Frame K character

  // Delay select picks one of the delay taps
  typedef logic [$clog2(`DELAY_DEPTH)-1:0] delay_sel_t;

  // --------------------
  // Received frame
  // --------------------
  typedef struct packed {
    gem_data_t data;    // Comparator bits
    k_char_t   k_char;  // Marker code sent with the data
  } gem_frame_t;

  // --------------------
  // Decoded markers
  // --------------------
  typedef struct packed {
    logic overflow;  // K code FC
    logic bc0;       // K code 1C
    logic resync;    // K code 3C
  } marker_t;

endpackage

/* verilog/gem_link_pkg.sv */
`include "gem_rx_settings.svh"

package gem_link_pkg;

  // --------------------
  // Counter widths
  // --------------------
  typedef logic [`COUNT_WIDTH-1:0]    count_t;     // Status and PRBS counters
  typedef logic [`LINK_ERR_WIDTH-1:0] link_err_t;  // Transceiver error counter

  // --------------------
  // Transceiver flags
  // --------------------
  typedef struct packed {
    logic start;      // Start pattern seen
    logic fc;         // FC code seen, for latency checks
    logic valid;      // Valid data on the link
    logic match;      // PRBS pattern matched
    logic sync_done;  // Receiver sync finished
    logic link_good;  // Link judged good
    logic link_bad;   // Link judged bad
  } link_flags_t;

  // --------------------
  // Registered status
  // --------------------
  typedef struct packed {
    logic start;      // Copy of start flag
    logic fc;         // Copy of fc flag
    logic valid;      // Copy of valid flag
    logic match;      // Copy of match flag
    logic sync_done;  // Copy of sync_done flag
    logic err;        // PRBS error on last sampled frame
  } rx_status_t;

endpackage

/* verilog/link_status_monitor.sv */
`timescale 1ns/100ps
`include "gem_rx_settings.svh"

module link_status_monitor (
  input  logic                      clock,             // 40 MHz fabric clock
  input  logic                      gtx_rx_reset,      // Async reset, active high
  input  logic                      clear_sync,        // Sync clear of status outputs
  input  logic                      prbs_test_en,      // PRBS test mode
  input  logic                      frame_strobe,      // One clock per frame period
  input  logic                      link_ready,        // Sync done and clocks locked
  input  gem_link_pkg::link_flags_t rx_link,           // Transceiver flags
  input  gem_link_pkg::link_err_t   link_errcount,     // Transceiver error count
  input  gem_link_pkg::count_t      notintable_count,  // Not-in-table count
  input  gem_link_pkg::count_t      disperr_count,     // Disparity error count
  output gem_link_pkg::rx_status_t  rx_status,         // Registered flags
  output gem_link_pkg::count_t      err_count,         // PRBS or link error count
  output gem_link_pkg::count_t      notintable_out,    // Registered not-in-table count
  output gem_link_pkg::count_t      disperr_out        // Registered disparity count
);

  // --------------------
  // PRBS error check
  // --------------------
  logic                 sample_en;     // Frame is checked this clock
  logic                 frame_bad;     // Valid frame that failed to match
  logic                 err;           // Error on last sampled frame
  gem_link_pkg::count_t prbs_count;    // Running PRBS error total
  gem_link_pkg::count_t link_err_ext;  // Link error count widened

  assign sample_en = link_ready & prbs_test_en & frame_strobe;  // Strobed frames only
  assign frame_bad = rx_link.valid & !rx_link.match;            // Valid means should match

  // Zero-extend the transceiver count to status width
  assign link_err_ext = {{(`COUNT_WIDTH-`LINK_ERR_WIDTH){1'b0}}, link_errcount};

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      err        <= 1'b0;
      prbs_count <= '0;
    end
    else if (!link_ready) begin  // Hold at zero until link is up
      err        <= 1'b0;
      prbs_count <= '0;
    end
    else if (sample_en) begin
      if (frame_bad) begin
        err        <= 1'b1;                                    // Flag this frame
        prbs_count <= prbs_count + gem_link_pkg::count_t'(1);  // Count it
      end
      else begin
        err <= 1'b0;  // Good frame drops the flag
      end
    end
  end

  // --------------------
  // Status register
  // --------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      rx_status      <= '0;
      err_count      <= '0;
      notintable_out <= '0;
      disperr_out    <= '0;
    end
    else if (clear_sync) begin  // Software clear
      rx_status      <= '0;
      err_count      <= '0;
      notintable_out <= '0;
      disperr_out    <= '0;
    end
    else begin
      rx_status.start     <= rx_link.start;      // Start pattern
      rx_status.fc        <= rx_link.fc;         // Latency code
      rx_status.valid     <= rx_link.valid;      // Valid data
      rx_status.match     <= rx_link.match;      // PRBS match
      rx_status.sync_done <= rx_link.sync_done;  // Sync finished
      rx_status.err       <= err;                // One clock behind the check

      // Test mode reports PRBS errors, otherwise link errors
      err_count      <= prbs_test_en ? prbs_count : link_err_ext;
      notintable_out <= notintable_count;  // Pass-through register
      disperr_out    <= disperr_count;     // Pass-through register
    end
  end

endmodule

/* verilog/comp_delay_line.sv */
`timescale 1ns/100ps
`include "gem_rx_settings.svh"

module comp_delay_line (
  input  logic                      clock,         // 40 MHz fabric clock
  input  logic                      gtx_rx_reset,  // Async reset, active high
  input  logic                      link_good,     // Link judged good
  input  logic                      link_bad,      // Link judged bad
  input  gem_frame_pkg::delay_sel_t delay_is,      // Total delay is this setting plus one
  input  gem_frame_pkg::gem_frame_t rx_frame,      // Frame from the transceiver
  output gem_frame_pkg::gem_frame_t gtx_rx_frame,  // Delayed guarded frame
  output gem_frame_pkg::marker_t    markers        // Decoded K markers
);

  gem_frame_pkg::delay_sel_t dly;                          // Registered delay select
  logic                      ignore_link;                  // Link unusable this clock
  gem_frame_pkg::gem_frame_t guarded_frame;                // Frame after link guard
  gem_frame_pkg::gem_frame_t taps [`DELAY_DEPTH];          // Delay chain

  // --------------------
  // Delay select
  // --------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      dly <= '0;
    end
    else begin
      dly <= delay_is;  // Tap pointer into the chain
    end
  end

  // --------------------
  // Link guard
  // --------------------
  // A bad link would show up downstream as hot comparators
  assign ignore_link = !link_good | link_bad;

  always_comb begin
    if (ignore_link) begin
      guarded_frame.data   = '1;  // All-ones data
      guarded_frame.k_char = '0;  // No marker
    end
    else begin
      guarded_frame = rx_frame;   // Link ok
    end
  end

  // --------------------
  // Delay chain
  // --------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      for (int i = 0; i < `DELAY_DEPTH; i++) begin
        taps[i] <= '0;
      end
    end
    else begin
      taps[0] <= guarded_frame;  // Newest frame
      for (int i = 1; i < `DELAY_DEPTH; i++) begin
        taps[i] <= taps[i-1];    // Shift toward older taps
      end
    end
  end

  // Output register adds the one clock minimum
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      gtx_rx_frame <= '0;
    end
    else begin
      gtx_rx_frame <= taps[dly];  // Selected tap
    end
  end

  // --------------------
  // Marker decode
  // --------------------
  assign markers.overflow = (gtx_rx_frame.k_char == `K_OVERFLOW);  // FC
  assign markers.bc0      = (gtx_rx_frame.k_char == `K_BC0);       // 1C
  assign markers.resync   = (gtx_rx_frame.k_char == `K_RESYNC);    // 3C

endmodule

/* verilog/gem_rx_top.sv */
`timescale 1ns/100ps

module gem_rx_top (
  input  logic                      clock,             // 40 MHz fabric clock
  input  logic                      gtx_rx_reset,      // Async reset, active high
  input  logic                      clear_sync,        // Sync clear of status outputs
  input  logic                      clocks_rdy,        // Clocks locked
  input  logic                      prbs_test_en,      // PRBS test mode
  input  logic                      frame_strobe,      // One clock per frame period
  input  gem_frame_pkg::delay_sel_t delay_is,          // Bunch-crossing delay setting
  input  gem_frame_pkg::gem_frame_t rx_frame,          // Received frame
  input  gem_link_pkg::link_flags_t rx_link,           // Transceiver flags
  input  gem_link_pkg::link_err_t   link_errcount,     // Transceiver error count
  input  gem_link_pkg::count_t      notintable_count,  // Not-in-table count
  input  gem_link_pkg::count_t      disperr_count,     // Disparity error count
  output gem_link_pkg::rx_status_t  rx_status,         // Registered flags
  output gem_link_pkg::count_t      err_count,         // PRBS or link error count
  output gem_link_pkg::count_t      notintable_out,    // Registered not-in-table count
  output gem_link_pkg::count_t      disperr_out,       // Registered disparity count
  output gem_frame_pkg::gem_frame_t gtx_rx_frame,      // Delayed guarded frame
  output gem_frame_pkg::marker_t    markers            // Decoded K markers
);

  logic link_ready;  // Receiver synced and clocks up

  // PRBS checks wait for both
  assign link_ready = rx_link.sync_done & clocks_rdy;

  // --------------------
  // Link status
  // --------------------
  link_status_monitor i_link_status_monitor (
    .clock            (clock),
    .gtx_rx_reset     (gtx_rx_reset),
    .clear_sync       (clear_sync),
    .prbs_test_en     (prbs_test_en),
    .frame_strobe     (frame_strobe),
    .link_ready       (link_ready),
    .rx_link          (rx_link),
    .link_errcount    (link_errcount),
    .notintable_count (notintable_count),
    .disperr_count    (disperr_count),
    .rx_status        (rx_status),
    .err_count        (err_count),
    .notintable_out   (notintable_out),
    .disperr_out      (disperr_out)
  );

  // --------------------
  // Frame delay
  // --------------------
  comp_delay_line i_comp_delay_line (
    .clock        (clock),
    .gtx_rx_reset (gtx_rx_reset),
    .link_good    (rx_link.link_good),  // Guard inputs
    .link_bad     (rx_link.link_bad),
    .delay_is     (delay_is),
    .rx_frame     (rx_frame),
    .gtx_rx_frame (gtx_rx_frame),
    .markers      (markers)
  );

endmodule

/* testbench/tb_gem_rx.sv */
`timescale 1ns/100ps
`include "gem_rx_settings.svh"

module tb_gem_rx;

  localparam int CLOCK_PERIOD = 40;                // ns
  localparam int DRIVE_DELAY  = 2;                 // Input skew after rising edge
  localparam int RESET_CYCLES = 16;
  localparam int HIST_DEPTH   = `DELAY_DEPTH + 1;  // Taps plus output register

  // One line of the trace file
  typedef struct packed {
    int                        cycles;         // Clocks this line is held
    logic                      clear;          // clear_sync
    logic                      rdy;            // clocks_rdy
    logic                      prbs;           // prbs_test_en
    int                        strobe_period;  // 0 means no strobe
    gem_frame_pkg::delay_sel_t delay;
    gem_frame_pkg::k_char_t    k_char;
    gem_link_pkg::link_flags_t flags;
    gem_link_pkg::link_err_t   lerr;
    gem_link_pkg::count_t      nit;
    gem_link_pkg::count_t      disp;
  } trace_step_t;

  // --------------------
  // DUT signals
  // --------------------
  logic                      clock;
  logic                      gtx_rx_reset;
  logic                      clear_sync;
  logic                      clocks_rdy;
  logic                      prbs_test_en;
  logic                      frame_strobe;
  gem_frame_pkg::delay_sel_t delay_is;
  gem_frame_pkg::gem_frame_t rx_frame;
  gem_link_pkg::link_flags_t rx_link;
  gem_link_pkg::link_err_t   link_errcount;
  gem_link_pkg::count_t      notintable_count;
  gem_link_pkg::count_t      disperr_count;
  gem_link_pkg::rx_status_t  rx_status;
  gem_link_pkg::count_t      err_count;
  gem_link_pkg::count_t      notintable_out;
  gem_link_pkg::count_t      disperr_out;
  gem_frame_pkg::gem_frame_t gtx_rx_frame;
  gem_frame_pkg::marker_t    markers;

  // --------------------
  // Testbench state
  // --------------------
  trace_step_t               steps[$];             // Trace lines in file order
  string                     names[$];             // Test tag per line
  int                        trace_cycles = 0;     // Sum of all line lengths
  bit                        trace_ready  = 1'b0;  // Starts the watchdog
  logic [31:0]               lfsr_state   = 32'hd23d;
  string                     test_name    = "";
  int                        test_checks  = 0;
  int                        test_errors  = 0;
  int                        total_errors = 0;
  int                        tests_run    = 0;
  int                        tests_failed = 0;

  gem_frame_pkg::gem_frame_t hist [HIST_DEPTH];  // hist[0] is the frame of the latest edge
  gem_frame_pkg::delay_sel_t d_prev;             // Delay seen one edge earlier
  logic                      m_err;              // Model PRBS error flag
  gem_link_pkg::count_t      m_cnt;              // Model PRBS count
  gem_frame_pkg::gem_frame_t exp_frame;
  gem_frame_pkg::marker_t    exp_markers;
  gem_link_pkg::rx_status_t  exp_status;
  gem_link_pkg::count_t      exp_err_count;
  gem_link_pkg::count_t      exp_nit;
  gem_link_pkg::count_t      exp_disp;

  gem_rx_top i_dut (
    .clock            (clock),
    .gtx_rx_reset     (gtx_rx_reset),
    .clear_sync       (clear_sync),
    .clocks_rdy       (clocks_rdy),
    .prbs_test_en     (prbs_test_en),
    .frame_strobe     (frame_strobe),
    .delay_is         (delay_is),
    .rx_frame         (rx_frame),
    .rx_link          (rx_link),
    .link_errcount    (link_errcount),
    .notintable_count (notintable_count),
    .disperr_count    (disperr_count),
    .rx_status        (rx_status),
    .err_count        (err_count),
    .notintable_out   (notintable_out),
    .disperr_out      (disperr_out),
    .gtx_rx_frame     (gtx_rx_frame),
    .markers          (markers)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;  // 25 MHz
  end

  // --------------------
  // Stimulus helpers
  // --------------------
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_data(output gem_frame_pkg::gem_data_t d);
    for (int b = 0; b < `GEM_DATA_WIDTH; b++) begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      d[b]       = lfsr_state[0];
    end
  endtask

  task automatic load_trace(output bit ok);
    int                        fd;
    int                        n;
    string                     line;
    string                     name;
    trace_step_t               step;
    int                        cycles;
    int                        sp;
    logic                      clr;
    logic                      rdy;
    logic                      prbs;
    gem_frame_pkg::delay_sel_t dly;
    gem_frame_pkg::k_char_t    k;
    gem_link_pkg::link_flags_t fl;
    gem_link_pkg::link_err_t   le;
    gem_link_pkg::count_t      nit;
    gem_link_pkg::count_t      disp;
    ok = 1'b0;
    fd = $fopen("testbench/gem_rx_trace.txt", "r");
    if (fd == 0) return;
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line[0] == "#") continue;  // Column notes
      n = $sscanf(line, "%s %d %d %d %d %d %h %h %b %h %h %h",
                  name, cycles, clr, rdy, prbs, sp, dly, k, fl, le, nit, disp);
      if (n <= 0) continue;                             // Blank line
      if (n != 12) begin
        $display("Trace line could not be parsed: %s", line);
        total_errors++;
        continue;
      end
      step.cycles        = cycles;
      step.clear         = clr;
      step.rdy           = rdy;
      step.prbs          = prbs;
      step.strobe_period = sp;
      step.delay         = dly;
      step.k_char        = k;
      step.flags         = fl;
      step.lerr          = le;
      step.nit           = nit;
      step.disp          = disp;
      steps.push_back(step);
      names.push_back(name);
      trace_cycles += cycles;
    end
    $fclose(fd);
    ok = 1'b1;
  endtask

  task automatic drive_inputs(input trace_step_t step, input int idx);
    gem_frame_pkg::gem_data_t d;
    random_data(d);
    clear_sync   = step.clear;
    clocks_rdy   = step.rdy;
    prbs_test_en = step.prbs;
    frame_strobe = 1'b0;
    if (step.strobe_period != 0) begin
      frame_strobe = (idx % step.strobe_period) == 0;  // First clock of each period
    end
    delay_is         = step.delay;
    rx_frame.data    = d;
    rx_frame.k_char  = step.k_char;
    rx_link          = step.flags;
    link_errcount    = step.lerr;
    notintable_count = step.nit;
    disperr_count    = step.disp;
  endtask

  // --------------------
  // Reference model
  // --------------------
  // Called once per edge with the inputs that edge sampled
  task automatic update_model();
    gem_frame_pkg::gem_frame_t guarded;
    logic                      ready;
    if (!rx_link.link_good || rx_link.link_bad) begin
      guarded.data   = '1;  // Unusable link
      guarded.k_char = '0;
    end
    else begin
      guarded = rx_frame;
    end
    for (int i = HIST_DEPTH - 1; i > 0; i--) begin
      hist[i] = hist[i-1];
    end
    hist[0]   = guarded;
    exp_frame = hist[int'(d_prev) + 1];  // Total delay is setting plus one
    d_prev    = delay_is;

    exp_markers.overflow = exp_frame.k_char == `K_OVERFLOW;
    exp_markers.bc0      = exp_frame.k_char == `K_BC0;
    exp_markers.resync   = exp_frame.k_char == `K_RESYNC;

    ready = rx_link.sync_done && clocks_rdy;
    if (clear_sync) begin
      exp_status    = '0;
      exp_err_count = '0;
      exp_nit       = '0;
      exp_disp      = '0;
    end
    else begin
      exp_status.start     = rx_link.start;
      exp_status.fc        = rx_link.fc;
      exp_status.valid     = rx_link.valid;
      exp_status.match     = rx_link.match;
      exp_status.sync_done = rx_link.sync_done;
      exp_status.err       = m_err;  // Flag from the previous sampled frame
      exp_err_count        = prbs_test_en ? m_cnt :
                             {{(`COUNT_WIDTH-`LINK_ERR_WIDTH){1'b0}}, link_errcount};
      exp_nit              = notintable_count;
      exp_disp             = disperr_count;
    end

    if (!ready) begin
      m_err = 1'b0;  // Held clear until link is up
      m_cnt = '0;
    end
    else if (prbs_test_en && frame_strobe) begin
      if (rx_link.valid && !rx_link.match) begin
        m_err = 1'b1;
        m_cnt = m_cnt + gem_link_pkg::count_t'(1);
      end
      else begin
        m_err = 1'b0;
      end
    end
  endtask

  // --------------------
  // Checking and report
  // --------------------
  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    test_checks++;
    if (expected !== actual) begin
      test_errors++;
      total_errors++;
      $display("** Error %s: %s expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_outputs();
    check_value("rx_status", 64'(exp_status), 64'(rx_status));
    check_value("err_count", 64'(exp_err_count), 64'(err_count));
    check_value("notintable_out", 64'(exp_nit), 64'(notintable_out));
    check_value("disperr_out", 64'(exp_disp), 64'(disperr_out));
    check_value("gtx_rx_frame", 64'(exp_frame), 64'(gtx_rx_frame));
    check_value("markers", 64'(exp_markers), 64'(markers));
  endtask

  // Every register straight out of reset, before any clock edge
  task automatic check_reset_values();
    exp_frame     = '0;
    exp_markers   = '0;
    exp_status    = '0;
    exp_err_count = '0;
    exp_nit       = '0;
    exp_disp      = '0;
    check_outputs();
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %s: %0d checks, no errors", test_name, test_checks);
    end
    else begin
      tests_failed++;
      $display("Test %s: FAILED, %0d of %0d checks wrong", test_name, test_errors, test_checks);
    end
  endtask

  // Outputs are stable here, and new inputs go out right after
  task automatic step_clock();
    @(posedge clock);
    #(DRIVE_DELAY);
    update_model();
    check_outputs();
  endtask

  task automatic run_trace();
    bit started;
    started = 1'b0;
    foreach (steps[l]) begin
      for (int i = 0; i < steps[l].cycles; i++) begin
        if (started) step_clock();
        if (names[l] != test_name) begin  // Tag change ends a test
          if (started) finish_test();
          test_name   = names[l];
          test_checks = 0;
          test_errors = 0;
        end
        if (!started) check_reset_values();  // Reset state before the first edge
        started = 1'b1;
        drive_inputs(steps[l], i);
      end
    end
    step_clock();  // Results of the last line
    finish_test();
  endtask

  initial begin : main
    bit ok;
    gtx_rx_reset     = 1'b1;
    clear_sync       = 1'b0;
    clocks_rdy       = 1'b0;
    prbs_test_en     = 1'b0;
    frame_strobe     = 1'b0;
    delay_is         = '0;
    rx_frame         = '0;
    rx_link          = '0;
    link_errcount    = '0;
    notintable_count = '0;
    disperr_count    = '0;
    for (int i = 0; i < HIST_DEPTH; i++) begin
      hist[i] = '0;  // Taps come out of reset at zero
    end
    d_prev = '0;
    m_err  = 1'b0;
    m_cnt  = '0;
    load_trace(ok);
    if (!ok) begin
      $display("Trace file testbench/gem_rx_trace.txt could not be opened");
      $display("Test failures found");
      $finish;
    end
    else begin
      trace_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge clock);
      #(DRIVE_DELAY) gtx_rx_reset = 1'b0;
      run_trace();
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
      if (total_errors == 0 && tests_failed == 0) begin
        $display("All tests passed!");
      end
      else begin
        $display("Test failures found");
      end
      $finish;
    end
  end

  // Twice the trace plus reset length
  initial begin : watchdog
    wait (trace_ready);
    #(2 * (trace_cycles + RESET_CYCLES) * CLOCK_PERIOD);
    $display("Timeout: the trace did not finish within %0d clocks",
             2 * (trace_cycles + RESET_CYCLES));
    $display("Test failures found");
    $finish;
  end

endmodule

/* gem_rx.f */
+incdir+include
verilog/gem_frame_pkg.sv
verilog/gem_link_pkg.sv
verilog/link_status_monitor.sv
verilog/comp_delay_line.sv
verilog/gem_rx_top.sv
testbench/tb_gem_rx.sv

/* Makefile */
TOP := tb_gem_rx

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f gem_rx.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q 'All tests passed!'

lint:
	verilator --lint-only -Wall --timing -f gem_rx.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* testbench/gem_rx_trace.txt */
# test cycles clear_sync clocks_rdy prbs_test_en strobe_period delay_is(hex) k_char(hex)
# rx_link(bin: start fc valid match sync_done link_good link_bad) link_errcount notintable disperr
reset_idle   20 0 0 0 0 0 00 0000000 00 0000 0000
delay_0      24 0 1 0 0 0 00 0000110 00 0000 0000
delay_5      24 0 1 0 0 5 00 0000110 00 0000 0000
delay_15     40 0 1 0 0 f 00 0000110 00 0000 0000
markers       1 0 1 0 0 3 fc 0000110 00 0000 0000
markers       2 0 1 0 0 3 00 0000110 00 0000 0000
markers       1 0 1 0 0 3 1c 0000110 00 0000 0000
markers       2 0 1 0 0 3 00 0000110 00 0000 0000
markers       1 0 1 0 0 3 3c 0000110 00 0000 0000
markers       1 0 1 0 0 3 bc 0000110 00 0000 0000
markers       1 0 1 0 0 3 7c 0000110 00 0000 0000
markers       1 0 1 0 0 3 f7 0000110 00 0000 0000
markers       8 0 1 0 0 3 00 0000110 00 0000 0000
link_guard    4 0 1 0 0 2 1c 0000110 00 0000 0000
link_guard    3 0 1 0 0 2 1c 0000100 00 0000 0000
link_guard    3 0 1 0 0 2 fc 0000111 00 0000 0000
link_guard    8 0 1 0 0 2 3c 0000110 00 0000 0000
prbs_count   16 0 1 1 4 0 00 0010110 00 0000 0000
prbs_count    8 0 1 1 4 0 00 0011110 00 0000 0000
prbs_count    8 0 1 1 0 0 00 0010110 00 0000 0000
prbs_count    8 0 0 1 4 0 00 0010110 00 0000 0000
prbs_count    9 0 1 1 3 0 00 0010110 00 0000 0000
link_errs     4 0 1 0 0 0 00 0010110 a5 0000 0000
link_errs     4 0 1 0 0 0 00 0000110 3c 0000 0000
status_clear  1 0 1 0 0 0 00 1101110 11 1234 0042
status_clear  1 1 1 0 0 0 00 1101110 11 1234 0042
status_clear  1 0 1 0 0 0 00 0110100 07 5678 0099
status_clear  1 0 1 1 1 0 00 1010110 22 9abc 0101
status_clear  2 1 1 1 1 0 00 1010110 22 9abc 0101
status_clear  4 0 1 0 0 0 00 0000110 00 0000 0000
